// File: core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Core package
// Shared types for the issue-and-execute core: instruction format,
// operation codes, unit input structs, writeback and trace records
////////////////////////////////////////////////////////////////////////////

package core_pkg;

    // Architectural register count
    localparam int NUM_REGS = 32;

    // Multiplier pipeline depth used by the top level
    localparam int MUL_LATENCY = 3;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_MUL
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction and issue records

    // Compact instruction word
    typedef struct packed {
        alu_op_t op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic signed [11:0] imm;
    } instr_t;

    // b already holds the immediate for the immediate form
    typedef struct packed {
        alu_op_t op;
        reg_addr_t rd;
        logic [31:0] a;
        logic [31:0] b;
    } alu_inputs_t;

    typedef struct packed {
        reg_addr_t rd;
        logic [31:0] a;
        logic [31:0] b;
    } mul_inputs_t;

    ////////////////////////////////////////////////////////////////////////////
    // Writeback, commit and trace records

    typedef struct packed {
        logic valid;
        reg_addr_t rd;
        logic [31:0] data;
    } unit_wb_t;

    typedef struct packed {
        logic valid;
        reg_addr_t rd;
        logic [31:0] data;
    } commit_t;

    typedef struct packed {
        logic instruction_issued;
        logic operand_stall;
        logic unit_stall;
        logic no_instruction_stall;
    } trace_events_t;

endpackage

// File: alu_unit.sv
////////////////////////////////////////////////////////////////////////////
// ALU unit
// Single-cycle integer ALU with a registered writeback record
////////////////////////////////////////////////////////////////////////////

module alu_unit import core_pkg::*; (
    input logic clk,
    input logic rst,

    input logic alu_valid,
    input alu_inputs_t alu_inputs,

    output unit_wb_t alu_wb
);

    logic [31:0] result;
    logic less_than;

    assign less_than = ($signed(alu_inputs.a) < $signed(alu_inputs.b));

    always_comb begin
        case (alu_inputs.op)
            OP_ADD:
                result = alu_inputs.a + alu_inputs.b;
            OP_SUB:
                result = alu_inputs.a - alu_inputs.b;
            OP_AND:
                result = alu_inputs.a & alu_inputs.b;
            OP_OR:
                result = alu_inputs.a | alu_inputs.b;
            OP_XOR:
                result = alu_inputs.a ^ alu_inputs.b;
            OP_SLT:
                result = {31'b0, less_than};
            default:
                result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback register
    always_ff @(posedge clk) begin
        alu_wb.rd <= alu_inputs.rd;
        alu_wb.data <= result;
        // Writes to x0 never reach the register file
        if (rst)
            alu_wb.valid <= 1'b0;
        else
            alu_wb.valid <= alu_valid & (alu_inputs.rd != '0);
    end

endmodule

// File: mul_unit.sv
////////////////////////////////////////////////////////////////////////////
// Multiplier unit
// Pipelined 32 x 32 multiplier returning the low word of the product,
// one new operation accepted per cycle
////////////////////////////////////////////////////////////////////////////

module mul_unit import core_pkg::*; #(
    parameter int MUL_LATENCY = core_pkg::MUL_LATENCY
) (
    input logic clk,
    input logic rst,

    input logic mul_valid,
    input mul_inputs_t mul_inputs,

    output unit_wb_t mul_wb
);

    // Each stage carries its own valid, destination and product
    unit_wb_t stage [MUL_LATENCY];
    logic [31:0] product_lo;

    // Only the low word is architecturally visible
    assign product_lo = mul_inputs.a * mul_inputs.b;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline
    always_ff @(posedge clk) begin
        stage[0].rd <= mul_inputs.rd;
        stage[0].data <= product_lo;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            stage[i].rd <= stage[i - 1].rd;
            stage[i].data <= stage[i - 1].data;
        end

        if (rst) begin
            for (int i = 0; i < MUL_LATENCY; i++)
                stage[i].valid <= 1'b0;
        end else begin
            stage[0].valid <= mul_valid & (mul_inputs.rd != '0);
            for (int i = 1; i < MUL_LATENCY; i++)
                stage[i].valid <= stage[i - 1].valid;
        end
    end

    assign mul_wb = stage[MUL_LATENCY - 1];

endmodule

// File: register_file.sv
////////////////////////////////////////////////////////////////////////////
// Register file
// 32 x 32 registers with x0 tied to zero, write-through reads, merge of
// the ALU and multiplier writebacks, and a registered commit port
////////////////////////////////////////////////////////////////////////////

module register_file import core_pkg::*; (
    input logic clk,
    input logic rst,

    input reg_addr_t rs1_addr,
    input reg_addr_t rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,

    input unit_wb_t alu_wb,
    input unit_wb_t mul_wb,

    output commit_t commit
);

    logic [31:0] regs [NUM_REGS];
    unit_wb_t wr;
    logic wr_en;

    // Issue control keeps the two units apart, so a plain select suffices
    assign wr = alu_wb.valid ? alu_wb : mul_wb;
    assign wr_en = wr.valid & (wr.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en)
            regs[wr.rd] <= wr.data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports
    always_comb begin
        if (rs1_addr == '0)
            rs1_data = '0;
        else if (wr_en && wr.rd == rs1_addr)
            rs1_data = wr.data;
        else
            rs1_data = regs[rs1_addr];
    end

    always_comb begin
        if (rs2_addr == '0)
            rs2_data = '0;
        else if (wr_en && wr.rd == rs2_addr)
            rs2_data = wr.data;
        else
            rs2_data = regs[rs2_addr];
    end

    // Commit updates at the same edge as the array
    always_ff @(posedge clk) begin
        commit.rd <= wr.rd;
        commit.data <= wr.data;
        if (rst)
            commit.valid <= 1'b0;
        else
            commit.valid <= wr_en;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    no_wb_collision : assert property (@(posedge clk) disable iff (rst)
        !(alu_wb.valid && mul_wb.valid));

endmodule

// File: issue_control.sv
////////////////////////////////////////////////////////////////////////////
// Issue control
// Four-phase instruction handshake into a one-entry holding register,
// decode, register scoreboard, multiplier writeback slot tracking and
// registered trace events
////////////////////////////////////////////////////////////////////////////

module issue_control import core_pkg::*; #(
    parameter int MUL_LATENCY = core_pkg::MUL_LATENCY
) (
    input logic clk,
    input logic rst,

    input instr_t instr,
    input logic instr_req,
    output logic instr_ack,

    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input logic [31:0] rs1_data,
    input logic [31:0] rs2_data,

    output logic alu_valid,
    output alu_inputs_t alu_inputs,
    output logic mul_valid,
    output mul_inputs_t mul_inputs,

    output trace_events_t trace
);

    instr_t hold_instr;
    logic hold_valid;
    logic capture;
    logic issue;

    logic is_mul;
    logic uses_rs2;
    logic rd_nonzero;

    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] wb_clear;
    logic [NUM_REGS-1:0] live_pending;
    logic [NUM_REGS-1:0] issue_set;
    logic operand_hazard;
    logic slot_conflict;

    // Outstanding ALU writeback, visible in the cycle after issue
    logic alu_wb_due;
    reg_addr_t alu_wb_rd;

    // Index 0 is the multiplier result written back in this cycle
    logic [MUL_LATENCY-1:0] mul_due;
    reg_addr_t mul_due_rd [MUL_LATENCY];

    trace_events_t trace_next;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake and holding register
    assign capture = instr_req & ~instr_ack & (~hold_valid | issue);

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_ack <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (capture)
                instr_ack <= 1'b1;
            else if (!instr_req)
                instr_ack <= 1'b0;

            if (capture)
                hold_valid <= 1'b1;
            else if (issue)
                hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            hold_instr <= instr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode and hazard checks
    assign is_mul = (hold_instr.op == OP_MUL);
    assign uses_rs2 = (hold_instr.op != OP_ADDI);
    assign rd_nonzero = (hold_instr.rd != '0);

    assign rs1_addr = hold_instr.rs1;
    assign rs2_addr = hold_instr.rs2;

    // Writes landing this cycle are read through the register file
    always_comb begin
        wb_clear = '0;
        if (alu_wb_due)
            wb_clear[alu_wb_rd] = 1'b1;
        if (mul_due[0])
            wb_clear[mul_due_rd[0]] = 1'b1;
    end

    assign live_pending = pending & ~wb_clear;

    assign operand_hazard = live_pending[hold_instr.rs1]
                          | (uses_rs2 & live_pending[hold_instr.rs2])
                          | live_pending[hold_instr.rd];

    // ALU result lands next cycle, so check the multiplier slot after this one
    generate
        if (MUL_LATENCY > 1) begin : g_slot_check
            assign slot_conflict = mul_due[1];
        end else begin : g_no_slot_check
            assign slot_conflict = 1'b0;
        end
    endgenerate

    assign issue = hold_valid & ~operand_hazard & (is_mul | ~slot_conflict);

    always_comb begin
        issue_set = '0;
        if (issue && rd_nonzero)
            issue_set[hold_instr.rd] = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard and writeback slots
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            alu_wb_due <= 1'b0;
            mul_due <= '0;
        end else begin
            pending <= live_pending | issue_set;
            alu_wb_due <= issue & ~is_mul & rd_nonzero;
            for (int i = 0; i < MUL_LATENCY - 1; i++)
                mul_due[i] <= mul_due[i + 1];
            mul_due[MUL_LATENCY - 1] <= issue & is_mul & rd_nonzero;
        end
    end

    always_ff @(posedge clk) begin
        alu_wb_rd <= hold_instr.rd;
        for (int i = 0; i < MUL_LATENCY - 1; i++)
            mul_due_rd[i] <= mul_due_rd[i + 1];
        mul_due_rd[MUL_LATENCY - 1] <= hold_instr.rd;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Unit issue
    assign alu_valid = issue & ~is_mul;
    assign mul_valid = issue & is_mul;

    assign alu_inputs.op = (hold_instr.op == OP_ADDI) ? OP_ADD : hold_instr.op;
    assign alu_inputs.rd = hold_instr.rd;
    assign alu_inputs.a = rs1_data;
    assign alu_inputs.b = uses_rs2 ? rs2_data : {{20{hold_instr.imm[11]}}, hold_instr.imm};

    assign mul_inputs.rd = hold_instr.rd;
    assign mul_inputs.a = rs1_data;
    assign mul_inputs.b = rs2_data;

    ////////////////////////////////////////////////////////////////////////////
    // Trace events
    assign trace_next.instruction_issued = issue;
    assign trace_next.operand_stall = hold_valid & operand_hazard;
    assign trace_next.unit_stall = hold_valid & ~operand_hazard & ~is_mul & slot_conflict;
    assign trace_next.no_instruction_stall = ~hold_valid;

    always_ff @(posedge clk) begin
        if (rst)
            trace <= '0;
        else
            trace <= trace_next;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    ack_needs_req : assert property (@(posedge clk) disable iff (rst)
        $rose(instr_ack) |-> $past(instr_req));

    single_unit_issue : assert property (@(posedge clk) disable iff (rst)
        !(alu_valid && mul_valid));

endmodule

// File: exec_core.sv
////////////////////////////////////////////////////////////////////////////
// Execution core top level
// Issue control, register file, ALU and pipelined multiplier, with the
// instruction handshake, commit port and trace events at the boundary
////////////////////////////////////////////////////////////////////////////

module exec_core import core_pkg::*; #(
    parameter int MUL_LATENCY = core_pkg::MUL_LATENCY
) (
    input logic clk,
    input logic rst,

    input instr_t instr,
    input logic instr_req,
    output logic instr_ack,

    output commit_t commit,
    output trace_events_t trace
);

    // Operand reads
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    // Unit issue
    logic alu_valid;
    alu_inputs_t alu_inputs;
    logic mul_valid;
    mul_inputs_t mul_inputs;

    // Unit writeback
    unit_wb_t alu_wb;
    unit_wb_t mul_wb;

    ////////////////////////////////////////////////////////////////////////////
    // Decode and issue
    issue_control #(
        .MUL_LATENCY(MUL_LATENCY)
    ) issue_control_block (.*);

    register_file register_file_block (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_block (.*);

    mul_unit #(
        .MUL_LATENCY(MUL_LATENCY)
    ) mul_unit_block (.*);

endmodule

// File: tb_exec_core.sv
////////////////////////////////////////////////////////////////////////////
// Execution core testbench
// Random four-phase instruction source with a program-order reference
// model; concurrent assertions check commits, handshake and reset state
////////////////////////////////////////////////////////////////////////////

module tb_exec_core import core_pkg::*; ();

    localparam int LATENCY = 3;
    localparam int NUM_INSTRS = 400;
    localparam int DRAIN_CYCLES = 30;
    localparam int WATCHDOG_CYCLES = NUM_INSTRS * 20;

    logic clk;
    logic rst;
    instr_t instr;
    logic instr_req;
    logic instr_ack;
    commit_t commit;
    trace_events_t trace;

    // Reference model state, registers x0 to x7 only
    logic [31:0] model_regs [8];
    logic [31:0] exp_mem [8][512];
    logic [8:0] head [8] = '{default: '0};
    logic [8:0] tail [8] = '{default: '0};
    logic [2:0] exp_index;
    logic [8:0] exp_count;
    logic [31:0] exp_head;

    int sent_count = 0;
    int issued_count = 0;
    logic seen_operand_stall = 1'b0;
    logic seen_unit_stall = 1'b0;
    logic rst_dly = 1'b0;
    logic clk_started = 1'b0;

    exec_core #(
        .MUL_LATENCY(LATENCY)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic logic [31:0] read_model(input reg_addr_t idx);
        // x0 always reads as zero
        if (idx == '0)
            return '0;
        return model_regs[idx[2:0]];
    endfunction

    function automatic logic [31:0] expected_result(input instr_t ins, input logic [31:0] a,
            input logic [31:0] b);
        case (ins.op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR: return a | b;
            OP_XOR: return a ^ b;
            OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: return a + {{20{ins.imm[11]}}, ins.imm};
            default: return a * b;
        endcase
    endfunction

    function automatic instr_t make_instr(input alu_op_t op, input int rd, input int rs1,
            input int rs2, input logic [11:0] imm);
        instr_t ins;
        ins.op = op;
        ins.rd = reg_addr_t'(rd);
        ins.rs1 = reg_addr_t'(rs1);
        ins.rs2 = reg_addr_t'(rs2);
        ins.imm = imm;
        return ins;
    endfunction

    // Entered and left a small delay after a rising edge with instr_ack low
    task automatic send_instr(input instr_t ins, input int gap);
        logic [31:0] result;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        instr = ins;
        instr_req = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!instr_ack);
        // Captured at this edge, so the model advances in program order
        result = expected_result(ins, read_model(ins.rs1), read_model(ins.rs2));
        if (ins.rd != '0) begin
            model_regs[ins.rd[2:0]] = result;
            exp_mem[ins.rd[2:0]][tail[ins.rd[2:0]]] = result;
            tail[ins.rd[2:0]] = tail[ins.rd[2:0]] + 1'b1;
        end
        sent_count++;
        instr_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (instr_ack);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Commit tracking
    always_comb begin
        exp_index = commit.rd[2:0];
        exp_count = tail[exp_index] - head[exp_index];
        exp_head = exp_mem[exp_index][head[exp_index]];
    end

    always_ff @(posedge clk) begin
        rst_dly <= rst;
        clk_started <= 1'b1;
        if (!rst && commit.valid && commit.rd != '0 && commit.rd < 8)
            head[commit.rd[2:0]] <= head[commit.rd[2:0]] + 1'b1;
        if (!rst && trace.instruction_issued)
            issued_count <= issued_count + 1;
        if (!rst && trace.operand_stall)
            seen_operand_stall <= 1'b1;
        if (!rst && trace.unit_stall)
            seen_unit_stall <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    commit_rd_nonzero : assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.rd != '0)
        else fail_run("Commit seen with destination x0");

    commit_rd_in_range : assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.rd < 8)
        else fail_run($sformatf("Commit to x%0d, which no instruction writes",
            $sampled(commit.rd)));

    commit_expected : assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> exp_count != '0)
        else fail_run($sformatf("Commit to x%0d with no write outstanding",
            $sampled(commit.rd)));

    commit_data_match : assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.data == exp_head)
        else fail_run($sformatf("Fail at time %0t: commit.data = %h, expected %h",
            $time, $sampled(commit.data), $sampled(exp_head)));

    ack_rise_with_req : assert property (@(posedge clk) disable iff (rst)
        $rose(instr_ack) |-> $past(instr_req))
        else fail_run("instr_ack rose while instr_req was low");

    ack_fall_after_req : assert property (@(posedge clk) disable iff (rst)
        $fell(instr_ack) |-> !$past(instr_req))
        else fail_run("instr_ack fell while instr_req was still high");

    req_rise_with_ack_low : assert property (@(posedge clk) disable iff (rst)
        $rose(instr_req) |-> !instr_ack)
        else fail_run("instr_req rose while instr_ack was high");

    // Each cycle is an issue, an operand stall, a unit stall or an empty slot
    trace_one_event : assert property (@(posedge clk) disable iff (rst)
        !rst_dly |-> $onehot(trace))
        else fail_run($sformatf("Fail at time %0t: trace = %b, expected exactly one bit set",
            $time, $sampled(trace)));

    // Covers the reset cycles and the first cycle after
    reset_outputs_low : assert property (@(posedge clk)
        (clk_started && (rst || rst_dly)) |-> (!instr_ack && !commit.valid && trace == '0))
        else fail_run($sformatf(
            "Fail at time %0t: instr_ack = %b, commit.valid = %b, trace = %b, expected 0",
            $time, $sampled(instr_ack), $sampled(commit.valid), $sampled(trace)));

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        string end_error;
        rst = 1'b1;
        instr_req = 1'b0;
        instr = '0;
        end_error = "";
        void'($urandom(38));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // Known values in every register, x0 included
        for (int i = 0; i < 8; i++)
            send_instr(make_instr(OP_ADDI, i, 0, 0, 12'($urandom)), 0);

        // Dependent multiplies, then an ALU op right behind a multiply
        send_instr(make_instr(OP_MUL, 5, 1, 2, 12'd0), 0);
        send_instr(make_instr(OP_MUL, 6, 5, 3, 12'd0), 0);
        send_instr(make_instr(OP_ADD, 4, 1, 2, 12'd0), 0);
        send_instr(make_instr(OP_MUL, 7, 1, 2, 12'd0), 4);
        send_instr(make_instr(OP_ADD, 3, 1, 2, 12'd0), 0);

        while (sent_count < NUM_INSTRS)
            send_instr(make_instr(alu_op_t'($urandom_range(7, 0)), $urandom_range(7, 0),
                $urandom_range(7, 0), $urandom_range(7, 0), 12'($urandom)),
                $urandom_range(3, 0));

        repeat (DRAIN_CYCLES) @(posedge clk);

        if (issued_count != sent_count)
            end_error = $sformatf("Fail at time %0t: issue count = %0d, expected %0d",
                $time, issued_count, sent_count);
        else if (!seen_operand_stall)
            end_error = "No operand stall was ever reported on the trace port";
        else if (!seen_unit_stall)
            end_error = "No unit stall was ever reported on the trace port";
        for (int i = 0; i < 8; i++) begin
            if (end_error == "" && head[i] != tail[i])
                end_error = $sformatf("Register x%0d still has %0d writes not committed",
                    i, tail[i] - head[i]);
        end

        if (end_error == "") begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run(end_error);
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Timeout: the run did not finish, a request may never have been acknowledged");
    end

endmodule

// File: sim.f
core_pkg.sv
alu_unit.sv
mul_unit.sv
register_file.sv
issue_control.sv
exec_core.sv
tb_exec_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module tb_exec_core -f sim.f \
    -o sim_exec_core > sim.log 2>&1 \
    && ./obj_dir/sim_exec_core >> sim.log 2>&1

cat sim.log

grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
